//--- design/stq_pkg.sv
`default_nettype none

package stq_pkg;

  localparam int STQ_DEPTH  = 8;
  localparam int STQ_IDX_W  = 3;
  localparam int STQ_ADDR_W = 36;

  typedef logic [STQ_IDX_W-1:0]  stq_idx_t;   // entry index.
  typedef logic [STQ_IDX_W:0]    stq_cnt_t;   // occupancy from 0 to STQ_DEPTH.
  typedef logic [STQ_ADDR_W-1:0] stq_addr_t;  // one line-address half.
  typedef logic [STQ_DEPTH-1:0]  stq_mask_t;  // one bit per entry.

  typedef enum logic [2:0] {
    STQ_NOP    = 3'd0,
    STQ_ALLOC  = 3'd1,  // write addresses at the tail.
    STQ_UPD    = 3'd2,  // store data written, by index.
    STQ_COMMIT = 3'd3,  // store retired, by index.
    STQ_DRAIN  = 3'd4,  // free the head entry.
    STQ_EXCPT  = 3'd5   // flush all stores not yet retired.
  } stq_op_e;

  typedef struct packed {
    stq_op_e   op;
    stq_idx_t  idx;
    stq_addr_t addr_e;
    stq_addr_t addr_o;
  } stq_cmd_t;

  typedef struct packed {
    logic      valid;
    stq_addr_t addr_e;
    stq_addr_t addr_o;
  } stq_chk_req_t;

  typedef struct packed {
    logic     valid;
    logic     hit_e;
    logic     hit_o;
    stq_idx_t idx;
  } stq_chk_rsp_t;

  typedef struct packed {
    stq_cnt_t count;
    logic     full;
    logic     empty;
    stq_idx_t head;
    stq_idx_t tail;
  } stq_status_t;

endpackage

`default_nettype wire

//--- design/stq_entry.sv
`timescale 1ns/1ps
`default_nettype none

module stq_entry import stq_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         wr_en,
  input  stq_addr_t    wr_addr_e,
  input  stq_addr_t    wr_addr_o,
  input  logic         upd_en,
  input  logic         passe_en,
  input  logic         free_en,
  input  logic         flush_en,
  input  stq_chk_req_t chk0,
  input  stq_chk_req_t chk1,
  output logic [1:0]   match0,
  output logic [1:0]   match1,
  output logic         free,
  output logic         upd,
  output logic         passe
);

  stq_addr_t addr_e;
  stq_addr_t addr_o;
  logic      live;

  // only stores that are allocated and not yet retired can forward.
  assign live = ~free & ~passe;

  assign match0[0] = chk0.valid && (chk0.addr_e == addr_e) && live;
  assign match0[1] = chk0.valid && (chk0.addr_o == addr_o) && live;
  assign match1[0] = chk1.valid && (chk1.addr_e == addr_e) && live;
  assign match1[1] = chk1.valid && (chk1.addr_o == addr_o) && live;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      addr_e <= wr_addr_e;
      addr_o <= wr_addr_o;
    end
  end

  // later statements take priority over earlier ones.
  always_ff @(posedge clk) begin
    if (rst) begin
      free  <= 1'b1;
      upd   <= 1'b1;
      passe <= 1'b0;
    end else begin
      if (wr_en) begin
        free  <= 1'b0;
        upd   <= 1'b0;
        passe <= 1'b0;
      end
      if (upd_en) upd <= 1'b1;  // data has arrived.
      if (passe_en) passe <= 1'b1;  // retired and waiting to drain.
      if (free_en) begin
        free  <= 1'b1;
        passe <= 1'b0;
      end
      if (flush_en) free <= 1'b1;  // speculative store squashed.
    end
  end

endmodule

`default_nettype wire

//--- design/stq_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module stq_entry_array import stq_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  stq_mask_t    wr_en,
  input  stq_mask_t    upd_en,
  input  stq_mask_t    passe_en,
  input  stq_mask_t    free_en,
  input  stq_mask_t    flush_en,
  input  stq_addr_t    wr_addr_e,
  input  stq_addr_t    wr_addr_o,
  input  stq_chk_req_t chk0,
  input  stq_chk_req_t chk1,
  output stq_mask_t    match0_e,
  output stq_mask_t    match0_o,
  output stq_mask_t    match1_e,
  output stq_mask_t    match1_o,
  output stq_mask_t    free,
  output stq_mask_t    upd,
  output stq_mask_t    passe
);

  for (genvar i = 0; i < STQ_DEPTH; i++) begin : g_entry
    logic [1:0] m0;
    logic [1:0] m1;

    stq_entry stq_entry_i (
      .clk       (clk),
      .rst       (rst),
      .wr_en     (wr_en[i]),
      .wr_addr_e (wr_addr_e),
      .wr_addr_o (wr_addr_o),
      .upd_en    (upd_en[i]),
      .passe_en  (passe_en[i]),
      .free_en   (free_en[i]),
      .flush_en  (flush_en[i]),
      .chk0      (chk0),
      .chk1      (chk1),
      .match0    (m0),
      .match1    (m1),
      .free      (free[i]),
      .upd       (upd[i]),
      .passe     (passe[i])
    );

    // bit 0 is the even half, bit 1 the odd half.
    assign match0_e[i] = m0[0];
    assign match0_o[i] = m0[1];
    assign match1_e[i] = m1[0];
    assign match1_o[i] = m1[1];
  end

endmodule

`default_nettype wire

//--- design/stq_ring_ptr.sv
`timescale 1ns/1ps
`default_nettype none

module stq_ring_ptr import stq_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        push,
  input  logic        pop,
  input  logic        rewind,
  input  stq_mask_t   passe,
  output stq_status_t status
);

  stq_idx_t head_q;
  stq_idx_t tail_q;
  stq_cnt_t count_q;
  stq_cnt_t passe_cnt;

  function automatic stq_cnt_t popcount(input stq_mask_t m);
    stq_cnt_t cnt;
    cnt = '0;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      cnt = cnt + stq_cnt_t'(m[i]);
    end
    return cnt;
  endfunction

  // retired stores sit contiguously from the head.
  assign passe_cnt = popcount(passe);

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (rewind) begin
      tail_q  <= head_q + passe_cnt[STQ_IDX_W-1:0];  // just past the retired ones.
      count_q <= passe_cnt;
    end else begin
      if (push) tail_q <= tail_q + stq_idx_t'(1);
      if (pop) head_q <= head_q + stq_idx_t'(1);
      case ({push, pop})
        2'b10:   count_q <= count_q + stq_cnt_t'(1);
        2'b01:   count_q <= count_q - stq_cnt_t'(1);
        default: count_q <= count_q;  // none, or both at once.
      endcase
    end
  end

  always_comb begin
    status.count = count_q;
    status.full  = (count_q == stq_cnt_t'(STQ_DEPTH));
    status.empty = (count_q == '0);
    status.head  = head_q;
    status.tail  = tail_q;
  end

endmodule

`default_nettype wire

//--- design/stq_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module stq_cmd_decode import stq_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  stq_cmd_t    cmd,
  input  stq_status_t status,
  input  stq_mask_t   free,
  input  stq_mask_t   upd,
  input  stq_mask_t   passe,
  output stq_mask_t   wr_en,
  output stq_mask_t   upd_en,
  output stq_mask_t   passe_en,
  output stq_mask_t   free_en,
  output stq_mask_t   flush_en,
  output logic        push,
  output logic        pop,
  output logic        rewind,
  output logic        cmd_err,
  output stq_idx_t    alloc_idx
);

  logic illegal;

  function automatic stq_mask_t onehot(input stq_idx_t i);
    return stq_mask_t'(1) << i;
  endfunction

  always_comb begin
    illegal  = 1'b0;
    wr_en    = '0;
    upd_en   = '0;
    passe_en = '0;
    free_en  = '0;
    flush_en = '0;
    push     = 1'b0;
    pop      = 1'b0;
    rewind   = 1'b0;
    case (cmd.op)
      STQ_ALLOC: begin
        illegal = status.full;
        wr_en   = illegal ? '0 : onehot(status.tail);
        push    = ~illegal;
      end
      STQ_UPD: begin
        illegal = free[cmd.idx];
        upd_en  = illegal ? '0 : onehot(cmd.idx);
      end
      STQ_COMMIT: begin
        illegal  = free[cmd.idx] | ~upd[cmd.idx];  // data must be in first.
        passe_en = illegal ? '0 : onehot(cmd.idx);
      end
      STQ_DRAIN: begin
        illegal = status.empty | ~passe[status.head];
        free_en = illegal ? '0 : onehot(status.head);
        pop     = ~illegal;
      end
      STQ_EXCPT: begin
        flush_en = ~passe;  // everything not yet retired.
        rewind   = 1'b1;
      end
      default: illegal = 1'b0;  // nop and unused codes.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_err   <= 1'b0;
      alloc_idx <= '0;
    end else begin
      cmd_err <= illegal;
      if (push) alloc_idx <= status.tail;
    end
  end

endmodule

`default_nettype wire

//--- design/stq_match_select.sv
`timescale 1ns/1ps
`default_nettype none

module stq_match_select import stq_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         chk0_valid,
  input  logic         chk1_valid,
  input  stq_mask_t    match0_e,
  input  stq_mask_t    match0_o,
  input  stq_mask_t    match1_e,
  input  stq_mask_t    match1_o,
  input  stq_idx_t     tail,
  output stq_chk_rsp_t rsp0,
  output stq_chk_rsp_t rsp1
);

  stq_idx_t sel0;
  stq_idx_t sel1;

  // Bit k of the rotated mask is entry tail-1-k, so the lowest set bit
  // is the youngest matching store. Returns 0 when nothing matches.
  function automatic stq_idx_t find_youngest(input stq_mask_t m, input stq_idx_t t);
    stq_mask_t rot;
    stq_idx_t  sel;
    logic      found;
    sel   = '0;
    found = 1'b0;
    for (int k = 0; k < STQ_DEPTH; k++) begin
      rot[k] = m[t - stq_idx_t'(1) - stq_idx_t'(k)];
    end
    for (int k = 0; k < STQ_DEPTH; k++) begin
      if (rot[k] && !found) begin
        sel   = t - stq_idx_t'(1) - stq_idx_t'(k);
        found = 1'b1;
      end
    end
    return sel;
  endfunction

  assign sel0 = find_youngest(match0_e | match0_o, tail);
  assign sel1 = find_youngest(match1_e | match1_o, tail);

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp0 <= '0;
      rsp1 <= '0;
    end else begin
      rsp0.valid <= chk0_valid;
      rsp0.hit_e <= |match0_e;
      rsp0.hit_o <= |match0_o;
      rsp0.idx   <= sel0;
      rsp1.valid <= chk1_valid;
      rsp1.hit_e <= |match1_e;
      rsp1.hit_o <= |match1_o;
      rsp1.idx   <= sel1;
    end
  end

endmodule

`default_nettype wire

//--- design/stq_top.sv
`timescale 1ns/1ps
`default_nettype none

module stq_top import stq_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  stq_cmd_t     cmd,
  input  stq_chk_req_t chk0,
  input  stq_chk_req_t chk1,
  output stq_chk_rsp_t rsp0,
  output stq_chk_rsp_t rsp1,
  output stq_status_t  status,
  output logic         cmd_err,
  output stq_idx_t     alloc_idx
);

  stq_mask_t wr_en;
  stq_mask_t upd_en;
  stq_mask_t passe_en;
  stq_mask_t free_en;
  stq_mask_t flush_en;
  stq_mask_t free;
  stq_mask_t upd;
  stq_mask_t passe;
  stq_mask_t match0_e;
  stq_mask_t match0_o;
  stq_mask_t match1_e;
  stq_mask_t match1_o;
  logic      push;
  logic      pop;
  logic      rewind;

  stq_cmd_decode stq_cmd_decode_i (
    .clk(clk), .rst(rst), .cmd(cmd), .status(status),
    .free(free), .upd(upd), .passe(passe),
    .wr_en(wr_en), .upd_en(upd_en), .passe_en(passe_en),
    .free_en(free_en), .flush_en(flush_en),
    .push(push), .pop(pop), .rewind(rewind),
    .cmd_err(cmd_err), .alloc_idx(alloc_idx)
  );

  stq_ring_ptr stq_ring_ptr_i (
    .clk(clk), .rst(rst), .push(push), .pop(pop), .rewind(rewind),
    .passe(passe), .status(status)
  );

  stq_entry_array stq_entry_array_i (
    .clk(clk), .rst(rst),
    .wr_en(wr_en), .upd_en(upd_en), .passe_en(passe_en),
    .free_en(free_en), .flush_en(flush_en),
    .wr_addr_e(cmd.addr_e), .wr_addr_o(cmd.addr_o),
    .chk0(chk0), .chk1(chk1),
    .match0_e(match0_e), .match0_o(match0_o),
    .match1_e(match1_e), .match1_o(match1_o),
    .free(free), .upd(upd), .passe(passe)
  );

  stq_match_select stq_match_select_i (
    .clk(clk), .rst(rst),
    .chk0_valid(chk0.valid), .chk1_valid(chk1.valid),
    .match0_e(match0_e), .match0_o(match0_o),
    .match1_e(match1_e), .match1_o(match1_o),
    .tail(status.tail),  // youngest store sits just below the tail.
    .rsp0(rsp0), .rsp1(rsp1)
  );

endmodule

`default_nettype wire

//--- test/tb_stq.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stq import stq_pkg::*; ();

  localparam string TRACE_FILE    = "test/stq_trace.txt";
  localparam int    RST_TIMEOUT   = 40;
  localparam int    DRAIN_TIMEOUT = 16;
  localparam int    MAX_LINES     = 512;
  localparam int    FIELDS        = 26;

  logic         clk;
  logic         rst;
  logic         rst_done;
  stq_cmd_t     cmd;
  stq_chk_req_t chk0;
  stq_chk_req_t chk1;
  stq_chk_rsp_t rsp0;
  stq_chk_rsp_t rsp1;
  stq_status_t  status;
  logic         cmd_err;
  stq_idx_t     alloc_idx;

  int              mismatches;
  int              failures;
  logic [8*16-1:0] test_name;  // label of the current trace line.

  stq_top stq_top_i (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .chk0      (chk0),
    .chk1      (chk1),
    .rsp0      (rsp0),
    .rsp1      (rsp1),
    .status    (status),
    .cmd_err   (cmd_err),
    .alloc_idx (alloc_idx)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  initial begin
    rst      = 1'b1;
    rst_done = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst      = 1'b0;
    rst_done = 1'b1;
  end

  function automatic string rsp_text(input stq_chk_rsp_t r);
    return $sformatf("valid=%0b hit_e=%0b hit_o=%0b idx=%0d",
                     r.valid, r.hit_e, r.hit_o, r.idx);
  endfunction

  function automatic string status_text(input stq_status_t s);
    return $sformatf("count=%0d full=%0b empty=%0b head=%0d tail=%0d",
                     s.count, s.full, s.empty, s.head, s.tail);
  endfunction

  task automatic check_rsp(input string port, input stq_chk_rsp_t exp, input stq_chk_rsp_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %0s %0s: expected %0s, actual %0s",
               test_name, port, rsp_text(exp), rsp_text(act));
    end
  endtask

  task automatic check_status(input stq_status_t exp, input stq_status_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %0s status: expected %0s, actual %0s",
               test_name, status_text(exp), status_text(act));
    end
  endtask

  task automatic check_err(input logic exp_err, input stq_idx_t exp_idx,
                           input logic act_err, input stq_idx_t act_idx);
    if (act_err !== exp_err || act_idx !== exp_idx) begin
      mismatches++;
      $display("Mismatch %0s cmd_err/alloc_idx: expected %0b/%0d, actual %0b/%0d",
               test_name, exp_err, exp_idx, act_err, act_idx);
    end
  endtask

  task automatic wait_reset(output logic ok);
    int cycles;
    cycles = 0;
    while (!rst_done && cycles < RST_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    ok = rst_done;
    if (!ok) begin
      failures++;
      $display("Reset was still active after %0d cycles", RST_TIMEOUT);
    end
  endtask

  // one vector per cycle. inputs go in on this falling edge, results
  // are checked on the next one.
  task automatic run_trace(output int lines);
    int           fd;
    int           code;
    int           n;
    string        line;
    logic [2:0]   v_op;
    stq_idx_t     v_idx, v_r0i, v_r1i, v_head, v_tail, v_aidx;
    stq_addr_t    v_ae, v_ao, v_c0e, v_c0o, v_c1e, v_c1o;
    logic         v_c0v, v_c1v, v_r0v, v_r0e, v_r0o, v_r1v, v_r1e, v_r1o;
    logic         v_full, v_empty, v_err;
    stq_cnt_t     v_cnt;
    stq_chk_rsp_t exp_rsp0;
    stq_chk_rsp_t exp_rsp1;
    stq_status_t  exp_status;
    lines = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      failures++;
      $display("Could not open the trace file %0s", TRACE_FILE);
    end else begin
      while (!$feof(fd) && lines < MAX_LINES) begin
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                      test_name, v_op, v_idx, v_ae, v_ao,
                      v_c0v, v_c0e, v_c0o, v_c1v, v_c1e, v_c1o,
                      v_r0v, v_r0e, v_r0o, v_r0i, v_r1v, v_r1e, v_r1o, v_r1i,
                      v_cnt, v_full, v_empty, v_head, v_tail, v_err, v_aidx);
          if (n != FIELDS) begin
            failures++;
            $display("Trace vector %0d has the wrong number of fields", lines + 1);
          end else begin
            cmd.op      = stq_op_e'(v_op);
            cmd.idx     = v_idx;
            cmd.addr_e  = v_ae;
            cmd.addr_o  = v_ao;
            chk0.valid  = v_c0v;
            chk0.addr_e = v_c0e;
            chk0.addr_o = v_c0o;
            chk1.valid  = v_c1v;
            chk1.addr_e = v_c1e;
            chk1.addr_o = v_c1o;
            exp_rsp0    = '{valid: v_r0v, hit_e: v_r0e, hit_o: v_r0o, idx: v_r0i};
            exp_rsp1    = '{valid: v_r1v, hit_e: v_r1e, hit_o: v_r1o, idx: v_r1i};
            exp_status  = '{count: v_cnt, full: v_full, empty: v_empty,
                            head: v_head, tail: v_tail};
            @(posedge clk);
            @(negedge clk);
            check_rsp("rsp0", exp_rsp0, rsp0);
            check_rsp("rsp1", exp_rsp1, rsp1);
            check_status(exp_status, status);
            check_err(v_err, v_aidx, cmd_err, alloc_idx);
            lines++;
          end
        end
      end
      $fclose(fd);
      if (lines == 0) begin
        failures++;
        $display("The trace file held no vectors");
      end
    end
  endtask

  // idle the inputs and let the last probe responses leave the register.
  task automatic drain_probes(output logic ok);
    int cycles;
    cmd    = '0;
    chk0   = '0;
    chk1   = '0;
    cycles = 0;
    while ((rsp0.valid || rsp1.valid) && cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    ok = !(rsp0.valid || rsp1.valid);
    if (!ok) begin
      failures++;
      $display("Probe responses were still valid %0d cycles after the trace", DRAIN_TIMEOUT);
    end
  endtask

  initial begin
    logic ok;
    int   lines;
    cmd        = '0;
    chk0       = '0;
    chk1       = '0;
    mismatches = 0;
    failures   = 0;
    lines      = 0;
    test_name  = '0;
    wait_reset(ok);
    if (ok) begin
      run_trace(lines);
      drain_probes(ok);
    end
    $display("summary: %0d vectors, %0d mismatches, %0d other errors",
             lines, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
design/stq_pkg.sv
design/stq_entry.sv
design/stq_entry_array.sv
design/stq_ring_ptr.sv
design/stq_cmd_decode.sv
design/stq_match_select.sv
design/stq_top.sv
test/tb_stq.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_stq
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/1ps
PASS_MSG  ?= all tests passed

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/stq_trace.txt
# name op idx addr_e addr_o | chk0 v e o | chk1 v e o | rsp0 v he ho idx | rsp1 v he ho idx
# | count full empty head tail | cmd_err alloc_idx   (all hex, results seen one cycle later)
reset     0 0 000 000 1 000 000 1 123 456 1 0 0 0 1 0 0 0 0 0 1 0 0 0 0
upd_free  2 3 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0
drn_empty 4 0 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0
alloc0    1 0 100 200 1 100 200 0 000 000 1 0 0 0 0 0 0 0 1 0 0 0 1 0 0
alloc1    1 0 101 201 1 100 200 1 100 999 1 1 1 0 1 1 0 0 2 0 0 0 2 0 1
alloc2    1 0 102 202 1 999 201 1 101 999 1 0 1 1 1 1 0 1 3 0 0 0 3 0 2
alloc3    1 0 100 203 1 100 999 0 000 000 1 1 0 0 0 0 0 0 4 0 0 0 4 0 3
alloc4    1 0 104 201 1 100 999 1 102 202 1 1 0 3 1 1 1 2 5 0 0 0 5 0 4
alloc5    1 0 105 205 1 999 201 1 100 201 1 0 1 4 1 1 1 4 6 0 0 0 6 0 5
alloc6    1 0 106 206 0 000 000 0 000 000 0 0 0 0 0 0 0 0 7 0 0 0 7 0 6
alloc7    1 0 107 207 1 106 999 0 000 000 1 1 0 6 0 0 0 0 8 1 0 0 0 0 7
alloc_ovf 1 0 108 208 1 107 207 0 000 000 1 1 1 7 0 0 0 0 8 1 0 0 0 1 7
cmt_noupd 3 0 000 000 1 108 208 0 000 000 1 0 0 0 0 0 0 0 8 1 0 0 0 1 7
drn_nocmt 4 0 000 000 1 100 999 0 000 000 1 1 0 3 0 0 0 0 8 1 0 0 0 1 7
upd0      2 0 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 8 1 0 0 0 0 7
upd1      2 1 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 8 1 0 0 0 0 7
cmt0      3 0 000 000 1 100 200 0 000 000 1 1 1 3 0 0 0 0 8 1 0 0 0 0 7
cmt1      3 1 000 000 1 100 200 1 999 201 1 1 0 3 1 0 1 4 8 1 0 0 0 0 7
retired   0 0 000 000 1 100 200 1 101 201 1 1 0 3 1 0 1 4 8 1 0 0 0 0 7
drain0    4 0 000 000 1 101 999 0 000 000 1 0 0 0 0 0 0 0 7 0 0 1 0 0 7
alloc_w   1 0 100 208 1 100 208 1 999 208 1 1 0 3 1 0 0 0 8 1 0 1 1 0 0
wrap_chk  0 0 000 000 1 100 208 1 999 208 1 1 1 0 1 0 1 0 8 1 0 1 1 0 0
upd2      2 2 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 8 1 0 1 1 0 0
cmt2      3 2 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 8 1 0 1 1 0 0
excpt     5 0 000 000 1 100 999 0 000 000 1 1 0 0 0 0 0 0 2 0 0 1 3 0 0
flushed   0 0 000 000 1 100 201 1 106 207 1 0 0 0 1 0 0 0 2 0 0 1 3 0 0
realloc3  1 0 300 400 0 000 000 0 000 000 0 0 0 0 0 0 0 0 3 0 0 1 4 0 3
realloc4  1 0 300 401 1 300 999 0 000 000 1 1 0 3 0 0 0 0 4 0 0 1 5 0 4
reuse     0 0 000 000 1 300 401 1 104 201 1 1 1 4 1 0 0 0 4 0 0 1 5 0 4
drain1    4 0 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 3 0 0 2 5 0 4
drain2    4 0 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 2 0 0 3 5 0 4
drn_live  4 0 000 000 0 000 000 0 000 000 0 0 0 0 0 0 0 0 2 0 0 3 5 1 4
excpt2    5 0 000 000 1 300 401 0 000 000 1 1 1 4 0 0 0 0 0 0 1 3 3 0 4
idle      0 0 000 000 1 300 401 1 300 000 1 0 0 0 1 0 0 0 0 0 1 3 3 0 4
